// File: verilog.f
+incdir+source
source/rvc_pkg.sv
source/rvc_fetch.sv
source/rvc_decoder.sv
source/rvc_frontend.sv
source/rvc_core_log.sv
source/rvc_wrapper.sv
test/rvc_sva.sv
test/rvc_tb.sv

// File: run.sh
#!/bin/sh
# Builds the RV32I front end testbench with Verilator and runs it.
# The result is taken from the simulation log.

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
SIM_BIN=rvc_sim
LOG=sim.log

verilator --binary --timing --assert -j 0 \
    --top-module rvc_tb \
    --Mdir "$BUILD_DIR" -o "$SIM_BIN" \
    -f verilog.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$BUILD_DIR/$SIM_BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^Test OK$" "$LOG"; then
    echo "Simulation passed"
    exit 0
else
    echo "Simulation did not pass, see $LOG"
    exit 1
fi

// File: test/rvc_tb.sv
/*
 * Testbench for the RV32I front end wrapper
 * Serves a table of instruction words from a memory model with random
 * grant and read-valid delays and checks every decoded result
 */
`timescale 1ns/1ps
`include "rvc_cfg.svh"

module rvc_tb;

    import rvc_pkg::*;

    localparam int NUM_ROWS     = 17;
    localparam int PAUSE_ROW    = 6;
    localparam int PAUSE_CYCLES = 12;
    localparam int DEC_TIMEOUT  = 64;
    localparam int GNT_TIMEOUT  = 400;

    typedef struct packed {
        logic [31:0]  word;
        instr_class_e cls;
        logic [4:0]   rd;
        logic [4:0]   rs1;
        logic [4:0]   rs2;
        logic [31:0]  imm;
        logic         ill;
    } row_t;

    logic                      clk_i;
    logic                      reset_i;
    logic                      fetch_enable_i;
    logic                      instr_req_o;
    logic [`RVC_XLEN-1:0]      instr_addr_o;
    logic                      instr_gnt_i;
    logic                      instr_rvalid_i;
    logic [`RVC_XLEN-1:0]      instr_rdata_i;
    logic                      dec_valid_o;
    instr_class_e              dec_class_o;
    logic [4:0]                dec_rd_o;
    logic [4:0]                dec_rs1_o;
    logic [4:0]                dec_rs2_o;
    logic [`RVC_XLEN-1:0]      dec_imm_o;
    logic                      dec_illegal_o;
    logic [`RVC_XLEN-1:0]      dec_pc_o;
    logic [`RVC_LOG_CNT_W-1:0] insn_count_o;
    logic [`RVC_LOG_CNT_W-1:0] illegal_count_o;
    logic                      first_illegal_valid_o;
    logic [`RVC_XLEN-1:0]      first_illegal_pc_o;

    row_t        rows [NUM_ROWS];
    int          errors;
    int          checks;
    int          req_count;
    int          decoded;
    int          row_errors;
    int          illegal_rows;
    int          first_illegal;
    bit          timed_out;
    bit          seen;

    rvc_wrapper dut (.*);

    initial begin
        clk_i = 1'b0;
        forever #50 clk_i = ~clk_i;
    end

    function automatic logic [31:0] fetch_word(input logic [31:0] addr);
        int idx;
        idx = int'((addr - `RVC_BOOT_ADDR) >> 2);
        // Past the table the memory returns a NOP
        return (idx >= 0 && idx < NUM_ROWS) ? rows[idx].word : 32'h0000_0013;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("Fail at %0t ns: %s is %h, expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    // One request at a time with a random grant and read-valid latency
    task automatic serve_memory();
        int          gnt_delay;
        int          rvalid_delay;
        logic [31:0] addr;
        forever begin
            @(posedge clk_i);
            if (instr_req_o) begin
                gnt_delay = $urandom_range(0, 3);
                repeat (gnt_delay) @(posedge clk_i);
                addr = instr_addr_o;
                check_value("instr_addr_o", addr, `RVC_BOOT_ADDR + 32'(req_count * 4));
                req_count++;
                instr_gnt_i <= 1'b1;
                @(posedge clk_i);
                instr_gnt_i <= 1'b0;
                rvalid_delay = $urandom_range(1, 3);
                repeat (rvalid_delay - 1) @(posedge clk_i);
                instr_rvalid_i <= 1'b1;
                instr_rdata_i  <= fetch_word(addr);
                @(posedge clk_i);
                instr_rvalid_i <= 1'b0;
            end
        end
    endtask

    task automatic wait_grant(input int row, output bit found);
        int          cycles;
        logic [31:0] target;
        found  = 1'b0;
        cycles = 0;
        target = `RVC_BOOT_ADDR + 32'(row * 4);
        while (!found && cycles < GNT_TIMEOUT) begin
            @(posedge clk_i);
            found = instr_req_o && instr_gnt_i && (instr_addr_o == target);
            cycles++;
        end
        if (!found) begin
            $display("Timeout: no grant seen for the request of row %0d", row);
            timed_out = 1'b1;
            errors++;
        end
    endtask

    // Pauses fetch after one grant, then stops it after the last row
    task automatic steer_fetch_enable();
        bit ok;
        wait_grant(PAUSE_ROW, ok);
        if (ok) begin
            fetch_enable_i <= 1'b0;
            repeat (PAUSE_CYCLES) begin
                @(posedge clk_i);
                check_value("instr_req_o", 32'(instr_req_o), 32'd0);
            end
            fetch_enable_i <= 1'b1;
            wait_grant(NUM_ROWS - 1, ok);
        end
        if (ok) begin
            fetch_enable_i <= 1'b0;
        end
    endtask

    task automatic wait_decode(output bit found);
        int cycles;
        found  = 1'b0;
        cycles = 0;
        while (!found && cycles < DEC_TIMEOUT) begin
            @(posedge clk_i);
            found = dec_valid_o;
            cycles++;
        end
    endtask

    initial begin
        void'($urandom(88));
        reset_i        = 1'b1;
        fetch_enable_i = 1'b0;
        instr_gnt_i    = 1'b0;
        instr_rvalid_i = 1'b0;
        instr_rdata_i  = '0;
        errors    = 0;
        checks    = 0;
        req_count = 0;
        decoded   = 0;
        timed_out = 1'b0;

        // Word, class, rd, rs1, rs2, immediate, illegal
        rows[0]  = '{32'h123452B7, CLS_LUI,     5'd5,  5'd0,  5'd0,  32'h1234_5000, 1'b0};
        rows[1]  = '{32'hFFFFF097, CLS_AUIPC,   5'd1,  5'd0,  5'd0,  32'hFFFF_F000, 1'b0};
        rows[2]  = '{32'hFF9FF0EF, CLS_JAL,     5'd1,  5'd0,  5'd0,  32'hFFFF_FFF8, 1'b0};
        rows[3]  = '{32'h00408067, CLS_JALR,    5'd0,  5'd1,  5'd0,  32'h0000_0004, 1'b0};
        rows[4]  = '{32'hFE2088E3, CLS_BRANCH,  5'd0,  5'd1,  5'd2,  32'hFFFF_FFF0, 1'b0};
        rows[5]  = '{32'hFFC12303, CLS_LOAD,    5'd6,  5'd2,  5'd0,  32'hFFFF_FFFC, 1'b0};
        rows[6]  = '{32'hFE742A23, CLS_STORE,   5'd0,  5'd8,  5'd7,  32'hFFFF_FFF4, 1'b0};
        rows[7]  = '{32'hFFF30293, CLS_OP_IMM,  5'd5,  5'd6,  5'd0,  32'hFFFF_FFFF, 1'b0};
        rows[8]  = '{32'h40355493, CLS_OP_IMM,  5'd9,  5'd10, 5'd0,  32'h0000_0403, 1'b0};
        rows[9]  = '{32'h40D605B3, CLS_OP,      5'd11, 5'd12, 5'd13, 32'h0000_0000, 1'b0};
        rows[10] = '{32'h00000073, CLS_SYSTEM,  5'd0,  5'd0,  5'd0,  32'h0000_0000, 1'b0};
        rows[11] = '{32'h0000000B, CLS_ILLEGAL, 5'd0,  5'd0,  5'd0,  32'h0000_0000, 1'b1};
        rows[12] = '{32'h00000001, CLS_ILLEGAL, 5'd0,  5'd0,  5'd0,  32'h0000_0000, 1'b1};
        rows[13] = '{32'h02B50533, CLS_ILLEGAL, 5'd0,  5'd0,  5'd0,  32'h0000_0000, 1'b1};
        rows[14] = '{32'h0000F083, CLS_ILLEGAL, 5'd0,  5'd0,  5'd0,  32'h0000_0000, 1'b1};
        rows[15] = '{32'h300110F3, CLS_ILLEGAL, 5'd0,  5'd0,  5'd0,  32'h0000_0000, 1'b1};
        rows[16] = '{32'h00100073, CLS_SYSTEM,  5'd0,  5'd0,  5'd0,  32'h0000_0001, 1'b0};

        repeat (4) @(posedge clk_i);
        reset_i        <= 1'b0;
        fetch_enable_i <= 1'b1;

        fork
            serve_memory();
            steer_fetch_enable();
        join_none

        for (int i = 0; i < NUM_ROWS; i++) begin
            wait_decode(seen);
            if (!seen) begin
                $display("Timeout: row %0d was never decoded", i);
                timed_out = 1'b1;
                errors++;
                break;
            end
            decoded++;
            row_errors = errors;
            check_value("dec_pc_o", dec_pc_o, `RVC_BOOT_ADDR + 32'(i * 4));
            check_value("dec_class_o", 32'(dec_class_o), 32'(rows[i].cls));
            check_value("dec_rd_o", 32'(dec_rd_o), 32'(rows[i].rd));
            check_value("dec_rs1_o", 32'(dec_rs1_o), 32'(rows[i].rs1));
            check_value("dec_rs2_o", 32'(dec_rs2_o), 32'(rows[i].rs2));
            check_value("dec_imm_o", dec_imm_o, rows[i].imm);
            check_value("dec_illegal_o", 32'(dec_illegal_o), 32'(rows[i].ill));
            $display("Row %2d word %h: %s", i, rows[i].word,
                     (errors == row_errors) ? "ok" : "mismatch");
        end

        if (!timed_out) begin
            // Fetch is stopped, so nothing may decode any more
            repeat (20) begin
                @(posedge clk_i);
                check_value("dec_valid_o", 32'(dec_valid_o), 32'd0);
            end
            illegal_rows  = 0;
            first_illegal = -1;
            for (int i = 0; i < NUM_ROWS; i++) begin
                if (rows[i].ill) begin
                    illegal_rows++;
                    if (first_illegal < 0) begin
                        first_illegal = i;
                    end
                end
            end
            row_errors = errors;
            check_value("insn_count_o", 32'(insn_count_o), NUM_ROWS);
            check_value("illegal_count_o", 32'(illegal_count_o), 32'(illegal_rows));
            check_value("first_illegal_valid_o", 32'(first_illegal_valid_o), 32'd1);
            check_value("first_illegal_pc_o", first_illegal_pc_o,
                        `RVC_BOOT_ADDR + 32'(first_illegal * 4));
            $display("Core log counters: %s", (errors == row_errors) ? "ok" : "mismatch");
        end

        $display("Summary: %0d of %0d rows decoded, %0d checks, %0d errors",
                 decoded, NUM_ROWS, checks, errors);
        if (errors == 0 && !timed_out) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// File: test/rvc_sva.sv
/*
 * Fetch handshake and decode timing assertions
 * Bound into the front end wrapper
 */
`timescale 1ns/1ps
`include "rvc_cfg.svh"

module rvc_sva (
    input logic                 clk_i,
    input logic                 reset_i,
    input logic                 instr_req_o,
    input logic [`RVC_XLEN-1:0] instr_addr_o,
    input logic                 instr_gnt_i,
    input logic                 instr_rvalid_i,
    input logic                 dec_valid_o
);

    logic pending_q;

    // Set by an accepted request, cleared by its read-valid
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            pending_q <= 1'b0;
        end else if (instr_req_o && instr_gnt_i) begin
            pending_q <= 1'b1;
        end else if (instr_rvalid_i) begin
            pending_q <= 1'b0;
        end
    end

    req_held_a: assert property (@(posedge clk_i) disable iff (reset_i)
        instr_req_o && !instr_gnt_i |=> instr_req_o && $stable(instr_addr_o))
        else $error("Request dropped or address changed before grant");

    no_req_pending_a: assert property (@(posedge clk_i) disable iff (reset_i)
        pending_q |-> !instr_req_o)
        else $error("New request raised while a read-valid is pending");

    dec_after_rvalid_a: assert property (@(posedge clk_i) disable iff (reset_i)
        instr_rvalid_i |=> dec_valid_o)
        else $error("Decode valid missing one cycle after read-valid");

    dec_only_after_rvalid_a: assert property (@(posedge clk_i) disable iff (reset_i)
        dec_valid_o |-> $past(instr_rvalid_i))
        else $error("Decode valid without a read-valid in the cycle before");

    dec_quiet_in_reset_a: assert property (@(posedge clk_i)
        reset_i |=> !dec_valid_o)
        else $error("Decode valid high during reset");

endmodule

bind rvc_wrapper rvc_sva sva_i (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .instr_req_o   (instr_req_o),
    .instr_addr_o  (instr_addr_o),
    .instr_gnt_i   (instr_gnt_i),
    .instr_rvalid_i(instr_rvalid_i),
    .dec_valid_o   (dec_valid_o)
);

// File: source/rvc_wrapper.sv
/*
 * Front end wrapper
 * Joins the RV32I front end with its core log block
 */
`timescale 1ns/1ps
`include "rvc_cfg.svh"

module rvc_wrapper (
    input  logic                      clk_i,
    input  logic                      reset_i,
    input  logic                      fetch_enable_i,

    // Instruction memory interface
    output logic                      instr_req_o,
    output logic [`RVC_XLEN-1:0]      instr_addr_o,
    input  logic                      instr_gnt_i,
    input  logic                      instr_rvalid_i,
    input  logic [`RVC_XLEN-1:0]      instr_rdata_i,

    // Decode stage
    output logic                      dec_valid_o,
    output rvc_pkg::instr_class_e     dec_class_o,
    output logic [4:0]                dec_rd_o,
    output logic [4:0]                dec_rs1_o,
    output logic [4:0]                dec_rs2_o,
    output logic [`RVC_XLEN-1:0]      dec_imm_o,
    output logic                      dec_illegal_o,
    output logic [`RVC_XLEN-1:0]      dec_pc_o,

    // Core log
    output logic [`RVC_LOG_CNT_W-1:0] insn_count_o,
    output logic [`RVC_LOG_CNT_W-1:0] illegal_count_o,
    output logic                      first_illegal_valid_o,
    output logic [`RVC_XLEN-1:0]      first_illegal_pc_o
);

    rvc_frontend core_i (
        .clk_i         (clk_i),
        .reset_i       (reset_i),
        .fetch_enable_i(fetch_enable_i),
        .instr_req_o   (instr_req_o),
        .instr_addr_o  (instr_addr_o),
        .instr_gnt_i   (instr_gnt_i),
        .instr_rvalid_i(instr_rvalid_i),
        .instr_rdata_i (instr_rdata_i),
        .dec_valid_o   (dec_valid_o),
        .dec_class_o   (dec_class_o),
        .dec_rd_o      (dec_rd_o),
        .dec_rs1_o     (dec_rs1_o),
        .dec_rs2_o     (dec_rs2_o),
        .dec_imm_o     (dec_imm_o),
        .dec_illegal_o (dec_illegal_o),
        .dec_pc_o      (dec_pc_o)
    );

    // Log observes the decode stage outputs directly
    rvc_core_log core_log_i (
        .clk_i                (clk_i),
        .reset_i              (reset_i),
        .dec_valid_i          (dec_valid_o),
        .dec_illegal_i        (dec_illegal_o),
        .dec_pc_i             (dec_pc_o),
        .insn_count_o         (insn_count_o),
        .illegal_count_o      (illegal_count_o),
        .first_illegal_valid_o(first_illegal_valid_o),
        .first_illegal_pc_o   (first_illegal_pc_o)
    );

endmodule

// File: source/rvc_core_log.sv
/*
 * Core log
 * Counts decoded and illegal instructions and records the PC of the
 * first illegal one
 */
`timescale 1ns/1ps
`include "rvc_cfg.svh"

module rvc_core_log (
    input  logic                     clk_i,
    input  logic                     reset_i,
    input  logic                     dec_valid_i,
    input  logic                     dec_illegal_i,
    input  logic [`RVC_XLEN-1:0]     dec_pc_i,

    output logic [`RVC_LOG_CNT_W-1:0] insn_count_o,
    output logic [`RVC_LOG_CNT_W-1:0] illegal_count_o,
    output logic                      first_illegal_valid_o,
    output logic [`RVC_XLEN-1:0]      first_illegal_pc_o
);

    // Increment that sticks at all ones
    function automatic logic [`RVC_LOG_CNT_W-1:0] sat_inc(
        input logic [`RVC_LOG_CNT_W-1:0] cnt
    );
        return (&cnt) ? cnt : cnt + `RVC_LOG_CNT_W'(1);
    endfunction

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            insn_count_o          <= '0;
            illegal_count_o       <= '0;
            first_illegal_valid_o <= 1'b0;
        end else if (dec_valid_i) begin
            insn_count_o <= sat_inc(insn_count_o);
            if (dec_illegal_i) begin
                illegal_count_o       <= sat_inc(illegal_count_o);
                first_illegal_valid_o <= 1'b1;
            end
        end
    end

    // Captured only while no illegal PC is held yet
    always_ff @(posedge clk_i) begin
        if (dec_valid_i && dec_illegal_i && !first_illegal_valid_o) begin
            first_illegal_pc_o <= dec_pc_i;
        end
    end

endmodule

// File: source/rvc_frontend.sv
/*
 * RV32I front end
 * Fetch engine followed by a registered decode stage
 */
`timescale 1ns/1ps
`include "rvc_cfg.svh"

module rvc_frontend (
    input  logic                  clk_i,
    input  logic                  reset_i,
    input  logic                  fetch_enable_i,

    output logic                  instr_req_o,
    output logic [`RVC_XLEN-1:0]  instr_addr_o,
    input  logic                  instr_gnt_i,
    input  logic                  instr_rvalid_i,
    input  logic [`RVC_XLEN-1:0]  instr_rdata_i,

    output logic                  dec_valid_o,
    output rvc_pkg::instr_class_e dec_class_o,
    output logic [4:0]            dec_rd_o,
    output logic [4:0]            dec_rs1_o,
    output logic [4:0]            dec_rs2_o,
    output logic [`RVC_XLEN-1:0]  dec_imm_o,
    output logic                  dec_illegal_o,
    output logic [`RVC_XLEN-1:0]  dec_pc_o
);

    import rvc_pkg::*;

    logic                 fetch_valid;
    instr_u               fetch_instr;
    logic [`RVC_XLEN-1:0] fetch_pc;
    instr_class_e         class_d;
    logic [4:0]           rd_d;
    logic [4:0]           rs1_d;
    logic [4:0]           rs2_d;
    logic [`RVC_XLEN-1:0] imm_d;
    logic                 illegal_d;

    rvc_fetch fetch_i (
        .clk_i         (clk_i),
        .reset_i       (reset_i),
        .fetch_enable_i(fetch_enable_i),
        .instr_req_o   (instr_req_o),
        .instr_addr_o  (instr_addr_o),
        .instr_gnt_i   (instr_gnt_i),
        .instr_rvalid_i(instr_rvalid_i),
        .instr_rdata_i (instr_rdata_i),
        .fetch_valid_o (fetch_valid),
        .fetch_instr_o (fetch_instr),
        .fetch_pc_o    (fetch_pc)
    );

    // Decodes the word while it arrives on the read data bus
    rvc_decoder decoder_i (
        .instr_i  (fetch_instr),
        .class_o  (class_d),
        .rd_o     (rd_d),
        .rs1_o    (rs1_d),
        .rs2_o    (rs2_d),
        .imm_o    (imm_d),
        .illegal_o(illegal_d)
    );

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            dec_valid_o <= 1'b0;
        end else begin
            dec_valid_o <= fetch_valid;
        end
    end

    // Decode stage register loads once per arriving word
    always_ff @(posedge clk_i) begin
        if (fetch_valid) begin
            dec_class_o   <= class_d;
            dec_rd_o      <= rd_d;
            dec_rs1_o     <= rs1_d;
            dec_rs2_o     <= rs2_d;
            dec_imm_o     <= imm_d;
            dec_illegal_o <= illegal_d;
            dec_pc_o      <= fetch_pc;
        end
    end

endmodule

// File: source/rvc_decoder.sv
/*
 * RV32I instruction decoder
 * Classifies one word, extracts register fields and the sign-extended
 * immediate, and flags illegal encodings
 */
`timescale 1ns/1ps
`include "rvc_cfg.svh"

module rvc_decoder (
    input  rvc_pkg::instr_u       instr_i,
    output rvc_pkg::instr_class_e class_o,
    output logic [4:0]            rd_o,
    output logic [4:0]            rs1_o,
    output logic [4:0]            rs2_o,
    output logic [`RVC_XLEN-1:0]  imm_o,
    output logic                  illegal_o
);

    import rvc_pkg::*;

    instr_class_e         cls;
    logic                 bad_fields;
    logic [2:0]           funct3;
    logic [6:0]           funct7;
    logic                 system_ok;
    logic [`RVC_XLEN-1:0] imm_i_type;
    logic [`RVC_XLEN-1:0] imm_s_type;
    logic [`RVC_XLEN-1:0] imm_b_type;
    logic [`RVC_XLEN-1:0] imm_u_type;
    logic [`RVC_XLEN-1:0] imm_j_type;

    assign funct3 = instr_i.r.funct3;
    assign funct7 = instr_i.r.funct7;

    // All immediate formats sign-extend from instruction bit 31
    assign imm_i_type = {{(`RVC_XLEN-12){instr_i.i.imm[11]}}, instr_i.i.imm};
    assign imm_s_type = {{(`RVC_XLEN-12){instr_i.s.imm_hi[6]}}, instr_i.s.imm_hi,
                         instr_i.s.imm_lo};
    assign imm_b_type = {{(`RVC_XLEN-12){instr_i.s.imm_hi[6]}}, instr_i.s.imm_lo[0],
                         instr_i.s.imm_hi[5:0], instr_i.s.imm_lo[4:1], 1'b0};
    assign imm_u_type = {instr_i.i.imm, instr_i.i.rs1, instr_i.i.funct3, 12'b0};
    assign imm_j_type = {{(`RVC_XLEN-20){instr_i.i.imm[11]}}, instr_i.i.rs1,
                         instr_i.i.funct3, instr_i.i.imm[0], instr_i.i.imm[10:1], 1'b0};

    // Only ECALL and EBREAK are accepted
    assign system_ok = (instr_i.i.imm == 12'h000 || instr_i.i.imm == 12'h001) &&
                       instr_i.i.rs1 == 5'd0 && funct3 == 3'd0 && instr_i.i.rd == 5'd0;

    always_comb begin
        cls        = CLS_ILLEGAL;
        bad_fields = 1'b0;
        if (instr_i.r.opcode[1:0] == 2'b11) begin
            case (instr_i.r.opcode)
                OPC_LUI:    cls = CLS_LUI;
                OPC_AUIPC:  cls = CLS_AUIPC;
                OPC_JAL:    cls = CLS_JAL;
                OPC_JALR: begin
                    cls        = CLS_JALR;
                    bad_fields = (funct3 != 3'd0);
                end
                OPC_BRANCH: begin
                    cls        = CLS_BRANCH;
                    bad_fields = (funct3 == 3'd2) || (funct3 == 3'd3);
                end
                OPC_LOAD: begin
                    cls        = CLS_LOAD;
                    bad_fields = funct3 inside {3'd3, 3'd6, 3'd7};
                end
                OPC_STORE: begin
                    cls        = CLS_STORE;
                    bad_fields = (funct3 > 3'd2);
                end
                OPC_OP_IMM: begin
                    cls        = CLS_OP_IMM;
                    bad_fields = (funct3 == 3'd1 && funct7 != 7'h00) ||
                                 (funct3 == 3'd5 && funct7 != 7'h00 && funct7 != 7'h20);
                end
                OPC_OP: begin
                    cls        = CLS_OP;
                    bad_fields = !(funct7 == 7'h00 ||
                                   (funct7 == 7'h20 && (funct3 == 3'd0 || funct3 == 3'd5)));
                end
                OPC_SYSTEM: begin
                    cls        = CLS_SYSTEM;
                    bad_fields = !system_ok;
                end
                default:    cls = CLS_ILLEGAL;
            endcase
        end
    end

    assign illegal_o = bad_fields || (cls == CLS_ILLEGAL);
    assign class_o   = illegal_o ? CLS_ILLEGAL : cls;

    // Fields a format does not carry read as zero
    always_comb begin
        rd_o  = instr_i.r.rd;
        rs1_o = instr_i.r.rs1;
        rs2_o = instr_i.r.rs2;
        imm_o = '0;
        case (class_o)
            CLS_LUI, CLS_AUIPC: begin
                rs1_o = 5'd0;
                rs2_o = 5'd0;
                imm_o = imm_u_type;
            end
            CLS_JAL: begin
                rs1_o = 5'd0;
                rs2_o = 5'd0;
                imm_o = imm_j_type;
            end
            CLS_JALR, CLS_LOAD, CLS_OP_IMM, CLS_SYSTEM: begin
                rs2_o = 5'd0;
                imm_o = imm_i_type;
            end
            CLS_BRANCH: begin
                rd_o  = 5'd0;
                imm_o = imm_b_type;
            end
            CLS_STORE: begin
                rd_o  = 5'd0;
                imm_o = imm_s_type;
            end
            CLS_OP: begin
                imm_o = '0;
            end
            default: begin
                rd_o  = 5'd0;
                rs1_o = 5'd0;
                rs2_o = 5'd0;
            end
        endcase
    end

endmodule

// File: source/rvc_fetch.sv
/*
 * Instruction fetch engine
 * Sequential PC from the boot address, one request outstanding at a time
 * on the request, grant and read-valid memory handshake
 */
`timescale 1ns/1ps
`include "rvc_cfg.svh"

module rvc_fetch (
    input  logic                 clk_i,
    input  logic                 reset_i,
    input  logic                 fetch_enable_i,

    // Instruction memory
    output logic                 instr_req_o,
    output logic [`RVC_XLEN-1:0] instr_addr_o,
    input  logic                 instr_gnt_i,
    input  logic                 instr_rvalid_i,
    input  logic [`RVC_XLEN-1:0] instr_rdata_i,

    // Fetched word towards decode
    output logic                 fetch_valid_o,
    output logic [`RVC_XLEN-1:0] fetch_instr_o,
    output logic [`RVC_XLEN-1:0] fetch_pc_o
);

    localparam logic [1:0] IDLE        = 2'd0;
    localparam logic [1:0] REQ         = 2'd1;
    localparam logic [1:0] WAIT_RVALID = 2'd2;

    logic [1:0]           state_q;
    logic [1:0]           state_d;
    logic [`RVC_XLEN-1:0] pc_q;
    logic [`RVC_XLEN-1:0] req_addr_q;
    logic                 req_accept;

    assign req_accept = instr_req_o && instr_gnt_i;

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (fetch_enable_i) begin
                    state_d = REQ;
                end
            end
            // Request is held until granted even if fetch is disabled meanwhile
            REQ: begin
                if (instr_gnt_i) begin
                    state_d = WAIT_RVALID;
                end
            end
            WAIT_RVALID: begin
                if (instr_rvalid_i) begin
                    state_d = fetch_enable_i ? REQ : IDLE;
                end
            end
            default: begin
                state_d = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state_q <= IDLE;
            pc_q    <= `RVC_BOOT_ADDR;
        end else begin
            state_q <= state_d;
            if (req_accept) begin
                pc_q <= pc_q + `RVC_XLEN'(4);
            end
        end
    end

    // Address of the granted request that travels with its read data
    always_ff @(posedge clk_i) begin
        if (req_accept) begin
            req_addr_q <= pc_q;
        end
    end

    assign instr_req_o  = (state_q == REQ);
    assign instr_addr_o = pc_q;

    assign fetch_valid_o = (state_q == WAIT_RVALID) && instr_rvalid_i;
    assign fetch_instr_o = instr_rdata_i;
    assign fetch_pc_o    = req_addr_q;

endmodule

// File: source/rvc_pkg.sv
/*
 * RV32I front end shared types
 * Major opcodes, instruction classes and the views of one instruction word
 */
package rvc_pkg;

    // RV32I major opcodes
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

    typedef enum logic [3:0] {
        CLS_LUI,
        CLS_AUIPC,
        CLS_JAL,
        CLS_JALR,
        CLS_BRANCH,
        CLS_LOAD,
        CLS_STORE,
        CLS_OP_IMM,
        CLS_OP,
        CLS_SYSTEM,
        CLS_ILLEGAL
    } instr_class_e;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } instr_r_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } instr_i_t;

    // The B format reuses this S layout
    typedef struct packed {
        logic [6:0] imm_hi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } instr_s_t;

    typedef union packed {
        instr_r_t r;
        instr_i_t i;
        instr_s_t s;
    } instr_u;

endpackage

// File: source/rvc_cfg.svh
/*
 * RV32I front end configuration
 * Datapath width, boot address and core log counter width
 */
`ifndef RVC_CFG_SVH
`define RVC_CFG_SVH

// Instruction and address width
`define RVC_XLEN 32

// First fetch address after reset
`define RVC_BOOT_ADDR 32'h0000_1000

// Width of the decoded and illegal instruction counters
`define RVC_LOG_CNT_W 16

`endif
